// File: Bender.yml
package:
  name: elevator

export_include_dirs:
  - .

sources:
  - elevator_pkg.sv
  - step_timer.sv
  - car_motion.sv
  - floor_call_cell.sv
  - target_selector.sv
  - passenger_counter.sv
  - elevator_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_elevator.sv

// File: car_motion.sv
// Car motion: stopped/up/down FSM and floor position register
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module car_motion (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      step,       // Move one floor when moving
    input  logic                      emergency,
    input  elevator_pkg::floor_t      target,     // From target selector
    output elevator_pkg::car_status_t status
);

    localparam elevator_pkg::floor_t TOP_FLOOR = elevator_pkg::floor_t'(`FLOORS - 1);

    elevator_pkg::motion_t motion;
    elevator_pkg::motion_t motion_next;
    elevator_pkg::floor_t  floor_q;               // Current floor

    // ==================================================
    // Next motion state
    // ==================================================
    always_comb begin
        motion_next = motion;                     // Hold by default
        if (emergency) begin
            // Head for the ground floor and park there
            motion_next = (floor_q == '0) ? elevator_pkg::MOTION_STOPPED
                                          : elevator_pkg::MOTION_DOWN;
        end else begin
            case (motion)
                elevator_pkg::MOTION_STOPPED: begin
                    if (target > floor_q)
                        motion_next = elevator_pkg::MOTION_UP;
                    else if (target < floor_q)
                        motion_next = elevator_pkg::MOTION_DOWN;
                end
                elevator_pkg::MOTION_UP,
                elevator_pkg::MOTION_DOWN: begin
                    if (floor_q == target)
                        motion_next = elevator_pkg::MOTION_STOPPED;  // Arrived
                end
                default: motion_next = elevator_pkg::MOTION_STOPPED;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            motion  <= elevator_pkg::MOTION_STOPPED;
            floor_q <= '0;
        end else begin
            motion <= motion_next;
            // Position only advances on a step while moving
            if (step && motion == elevator_pkg::MOTION_UP && floor_q < TOP_FLOOR)
                floor_q <= floor_q + 1'b1;
            else if (step && motion == elevator_pkg::MOTION_DOWN && floor_q != '0)
                floor_q <= floor_q - 1'b1;
        end
    end

    assign status = '{floor: floor_q, motion: motion};

    // Position in range, and frozen while parked
    a_floor_range: assert property (@(posedge clock) disable iff (reset)
        floor_q < `FLOORS);
    a_no_drift: assert property (@(posedge clock) disable iff (reset)
        motion == elevator_pkg::MOTION_STOPPED |=> $stable(floor_q));

endmodule

`default_nettype wire

// File: elevator_defines.svh
// Elevator sizing macros: floor count, widths, passenger limit, step period
`ifndef ELEVATOR_DEFINES_SVH
`define ELEVATOR_DEFINES_SVH

// ==================================================
// Building geometry
// ==================================================
`define FLOORS          5   // Floors 0 to 4
`define FLOOR_BITS      3   // Wide enough for any floor index

// ==================================================
// Car limits and timing
// ==================================================
`define MAX_PASSENGERS  5   // Occupancy that marks the car as full
`define COUNT_BITS      3   // Passenger count width
`define STEP_CYCLES     8   // Clocks per floor step, at least 2

`endif

// File: elevator_patterns.txt
# Columns: command name, then one hex argument
# press=floor mask, wait_moving=1 up 2 down, wait_stopped=floor, expect_full=level, enter/exit/idle=count
# After reset
expect_full 0
wait_stopped 0
# Single call
press 08
wait_moving 1
wait_stopped 3
# Nearest first when stopped
press 11
wait_moving 1
wait_stopped 4
wait_moving 2
wait_stopped 0
# On-path pickup
press 10
wait_moving 1
press 04
wait_stopped 2
wait_moving 1
wait_stopped 4
# Full car skips pickups
press 01
wait_moving 2
wait_stopped 0
enter 5
expect_full 1
enter 1
expect_full 1
press 10
wait_moving 1
press 04
wait_stopped 4
wait_moving 2
wait_stopped 2
# Occupancy rules
exit 1
expect_full 0
press 01
wait_moving 2
enter 1
expect_full 0
wait_stopped 0
enter 1
expect_full 1
# Emergency
press 18
wait_moving 1
idle 0a
hold_emergency 0
wait_stopped 0
release_emergency 0
idle 0a
wait_stopped 0

// File: elevator_pkg.sv
// Elevator types: floor index, motion state, car status, per-floor candidate
`default_nettype none

`include "elevator_defines.svh"

package elevator_pkg;

    typedef logic [`FLOOR_BITS-1:0] floor_t;   // Floor index

    // Car motion, same encoding as the status flags
    typedef enum logic [1:0] {
        MOTION_STOPPED = 2'b00,
        MOTION_UP      = 2'b01,
        MOTION_DOWN    = 2'b10
    } motion_t;

    // Where the car is and what it is doing
    typedef struct packed {
        floor_t  floor;
        motion_t motion;
    } car_status_t;

    // One per floor, read by the target selector
    typedef struct packed {
        logic   pending;                        // Call latched here
        logic   on_path;                        // Between car and target
        floor_t distance;                       // Floors away from the car
    } floor_candidate_t;

endpackage

`default_nettype wire

// File: elevator_top.sv
// Elevator top level: step timer, car motion, call cells, selector, counter
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module elevator_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`FLOORS-1:0]     call_buttons,  // One hall button per floor
    input  logic                   emergency,
    input  logic                   person_enter,
    input  logic                   person_exit,
    output logic [`FLOOR_BITS-1:0] floor,         // Binary floor number
    output logic                   stopped,
    output logic                   moving_up,
    output logic                   moving_down,
    output logic                   full
);

    logic                           step;
    elevator_pkg::car_status_t      status;
    elevator_pkg::floor_t           target;
    elevator_pkg::floor_candidate_t candidates [`FLOORS];

    // ==================================================
    // Motion path
    // ==================================================
    step_timer i_step_timer (
        .clock (clock),
        .reset (reset),
        .step  (step)
    );

    car_motion i_car_motion (
        .clock     (clock),
        .reset     (reset),
        .step      (step),
        .emergency (emergency),
        .target    (target),
        .status    (status)
    );

    // ==================================================
    // Calls and destination
    // ==================================================
    for (genvar i = 0; i < `FLOORS; i++) begin : g_floor
        floor_call_cell #(.FLOOR_INDEX(i)) i_floor_call_cell (
            .clock     (clock),
            .reset     (reset),
            .call      (call_buttons[i]),
            .emergency (emergency),
            .status    (status),
            .target    (target),
            .candidate (candidates[i])
        );
    end

    target_selector i_target_selector (
        .clock      (clock),
        .reset      (reset),
        .emergency  (emergency),
        .full       (full),
        .status     (status),
        .candidates (candidates),
        .target     (target)
    );

    passenger_counter i_passenger_counter (
        .clock        (clock),
        .reset        (reset),
        .person_enter (person_enter),
        .person_exit  (person_exit),
        .status       (status),
        .full         (full)
    );

    // Status outputs
    assign floor       = status.floor;
    assign stopped     = (status.motion == elevator_pkg::MOTION_STOPPED);
    assign moving_up   = (status.motion == elevator_pkg::MOTION_UP);
    assign moving_down = (status.motion == elevator_pkg::MOTION_DOWN);

endmodule

`default_nettype wire

// File: floor_call_cell.sv
// Floor call cell: hall-call latch plus distance and on-path evaluation
`timescale 1ns/1ps
`default_nettype none

module floor_call_cell #(
    parameter int FLOOR_INDEX = 0                   // Floor served by this cell
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           call,       // Hall button level
    input  logic                           emergency,
    input  elevator_pkg::car_status_t      status,
    input  elevator_pkg::floor_t           target,
    output elevator_pkg::floor_candidate_t candidate
);

    localparam elevator_pkg::floor_t MY_FLOOR = elevator_pkg::floor_t'(FLOOR_INDEX);

    logic                 pending;
    logic                 at_floor;                 // Car parked here
    logic                 on_path;
    elevator_pkg::floor_t distance;

    assign at_floor = (status.motion == elevator_pkg::MOTION_STOPPED)
                   && (status.floor == MY_FLOOR);

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            pending <= 1'b0;
        else if (emergency || at_floor)
            pending <= 1'b0;                        // Clear beats a press
        else if (call)
            pending <= 1'b1;
    end

    always_comb begin
        distance = (MY_FLOOR > status.floor) ? MY_FLOOR - status.floor
                                             : status.floor - MY_FLOOR;
        case (status.motion)
            elevator_pkg::MOTION_UP:   on_path = (MY_FLOOR > status.floor) && (MY_FLOOR <= target);
            elevator_pkg::MOTION_DOWN: on_path = (MY_FLOOR < status.floor) && (MY_FLOOR >= target);
            default:                   on_path = 1'b0;  // No path while parked
        endcase
    end

    assign candidate = '{pending: pending, on_path: on_path, distance: distance};

    // A call at the floor the car rests on is served, never kept
    a_served_clears: assert property (@(posedge clock) disable iff (reset)
        at_floor |=> !pending);

endmodule

`default_nettype wire

// File: list.f
+incdir+.
elevator_pkg.sv
step_timer.sv
car_motion.sv
floor_call_cell.sv
target_selector.sv
passenger_counter.sv
elevator_top.sv
tb_clock_gen.sv
tb_elevator.sv

// File: passenger_counter.sv
// Passenger counter: edge-detected enter/exit, saturating count, full flag
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module passenger_counter (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      person_enter,  // Level, counted on rise
    input  logic                      person_exit,
    input  elevator_pkg::car_status_t status,
    output logic                      full
);

    localparam logic [`COUNT_BITS-1:0] MAX_COUNT = `MAX_PASSENGERS;

    logic                   enter_q, exit_q;         // Previous levels
    logic                   enter_rise, exit_rise;
    logic [`COUNT_BITS-1:0] count, count_next;

    assign enter_rise = person_enter & ~enter_q;
    assign exit_rise  = person_exit & ~exit_q;

    always_comb begin
        count_next = count;
        // Doors only open while parked
        if (status.motion == elevator_pkg::MOTION_STOPPED) begin
            if (enter_rise) begin
                if (count < MAX_COUNT)
                    count_next = count + 1'b1;       // Saturate at limit
            end else if (exit_rise && count != '0) begin
                count_next = count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            enter_q <= 1'b0;
            exit_q  <= 1'b0;
            count   <= '0;
            full    <= 1'b0;
        end else begin
            enter_q <= person_enter;
            exit_q  <= person_exit;
            count   <= count_next;
            full    <= (count_next == MAX_COUNT);    // Tracks count same clock
        end
    end

    a_count_limit: assert property (@(posedge clock) disable iff (reset)
        count <= MAX_COUNT);

endmodule

`default_nettype wire

// File: step_timer.sv
// Step timer: free-running divider producing a one-clock step strobe
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module step_timer #(
    parameter int STEP_CYCLES = `STEP_CYCLES   // Clocks between strobes
) (
    input  logic clock,
    input  logic reset,
    output logic step                          // High for one clock per period
);

    localparam int CNT_BITS = $clog2(STEP_CYCLES);
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(STEP_CYCLES - 1);

    logic [CNT_BITS-1:0] count;                // Clocks since last strobe

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
            step  <= 1'b0;
        end else if (count == LAST) begin
            count <= '0;                       // Wrap
            step  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            step  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: target_selector.sv
// Target selector: registered destination chosen from per-floor candidates
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module target_selector (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           emergency,
    input  logic                           full,        // No pickups when full
    input  elevator_pkg::car_status_t      status,
    input  elevator_pkg::floor_candidate_t candidates [`FLOORS],
    output elevator_pkg::floor_t           target
);

    logic                 moving;
    logic                 found;                        // Some floor qualifies
    elevator_pkg::floor_t best_floor;
    elevator_pkg::floor_t best_dist;
    elevator_pkg::floor_t target_next;

    assign moving = (status.motion != elevator_pkg::MOTION_STOPPED);

    // ==================================================
    // Nearest eligible floor
    // ==================================================
    always_comb begin
        best_floor = status.floor;
        best_dist  = '1;
        found      = 1'b0;
        // Ascending scan with strict compare, ties go low
        for (int i = 0; i < `FLOORS; i++) begin
            if (candidates[i].pending && (candidates[i].on_path || !moving)
                && candidates[i].distance < best_dist) begin
                best_floor = elevator_pkg::floor_t'(i);
                best_dist  = candidates[i].distance;
                found      = 1'b1;
            end
        end
    end

    always_comb begin
        target_next = target;                           // Keep by default
        if (emergency)
            target_next = '0;                           // Ground floor
        else if (!moving)
            target_next = found ? best_floor : status.floor;
        else if (!full && found)
            target_next = best_floor;                   // On-path pickup
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            target <= '0;
        else
            target <= target_next;
    end

    a_target_range: assert property (@(posedge clock) disable iff (reset)
        target < `FLOORS);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock source: free-running square wave of a set period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100           // Full period in ns
) (
    output logic clock
);

    initial begin
        clock = 1'b0;                       // Start low, first rise at half period
    end

    always begin
        #(PERIOD_NS / 2) clock = ~clock;
    end

endmodule

`default_nettype wire

// File: tb_elevator.sv
// Elevator testbench with pattern reader, stimulus tasks, timed waits and output checks
`timescale 1ns/1ps
`default_nettype none

`include "elevator_defines.svh"

module tb_elevator;

    localparam int WAIT_LIMIT = 200;            // Cycles before any wait gives up

    logic                   clock;
    logic                   reset;
    logic [`FLOORS-1:0]     call_buttons;
    logic                   emergency;
    logic                   person_enter;
    logic                   person_exit;
    logic [`FLOOR_BITS-1:0] floor;
    logic                   stopped;
    logic                   moving_up;
    logic                   moving_down;
    logic                   full;

    integer           fd;                       // Pattern file handle
    logic [8*24-1:0]  cmd;                      // Command word
    logic [31:0]      arg;                      // Hex argument
    logic [8*256-1:0] comment_text;             // Rest of a comment line
    logic [31:0]      seed;
    int               commands_run;

    tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clock(clock));

    elevator_top i_elevator_top (
        .clock        (clock),
        .reset        (reset),
        .call_buttons (call_buttons),
        .emergency    (emergency),
        .person_enter (person_enter),
        .person_exit  (person_exit),
        .floor        (floor),
        .stopped      (stopped),
        .moving_up    (moving_up),
        .moving_down  (moving_down),
        .full         (full)
    );

    // ==================================================
    // Reporting
    // ==================================================
    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "simulation halted at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    // ==================================================
    // Stimulus driven on the falling edge
    // ==================================================
    task automatic press_buttons(input logic [`FLOORS-1:0] mask);
        call_buttons = mask;                    // Held for one clock
        @(negedge clock);
        call_buttons = '0;
    endtask

    task automatic pulse_passenger(input bit leaving, input int count);
        repeat (count) begin
            if (leaving)
                person_exit = 1'b1;
            else
                person_enter = 1'b1;
            @(negedge clock);
            person_enter = 1'b0;                // Low again so the next rise counts
            person_exit  = 1'b0;
            @(negedge clock);
        end
    endtask

    task automatic set_emergency(input logic level);
        emergency = level;
        @(negedge clock);                       // Motion has reacted by now
    endtask

    // ==================================================
    // Waits with timeouts
    // ==================================================
    task automatic wait_for_motion(input logic [31:0] direction);
        int cycles;
        cycles = 0;
        while (!(moving_up || moving_down) && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!(moving_up || moving_down)) begin
            $display("ERROR: car never started moving within %0d cycles", WAIT_LIMIT);
            stop_run();
        end else begin
            check_value("moving_up", moving_up, direction == 1);    // 1 means up
            check_value("moving_down", moving_down, direction == 2); // 2 means down
        end
    endtask

    task automatic wait_for_stop(input logic [31:0] expected_floor);
        int cycles;
        cycles = 0;
        while (!stopped && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!stopped) begin
            $display("ERROR: car never came to a stop within %0d cycles", WAIT_LIMIT);
            stop_run();
        end else begin
            check_value("floor", floor, expected_floor);
        end
    endtask

    // ==================================================
    // Pattern file
    // ==================================================
    task automatic run_command(input int fields);
        if (fields != 1) begin
            $display("ERROR: pattern command %0s has no hex argument", cmd);
            stop_run();
        end else if (cmd == "press")
            press_buttons(arg[`FLOORS-1:0]);
        else if (cmd == "hold_emergency")
            set_emergency(1'b1);
        else if (cmd == "release_emergency")
            set_emergency(1'b0);
        else if (cmd == "enter")
            pulse_passenger(1'b0, arg);
        else if (cmd == "exit")
            pulse_passenger(1'b1, arg);
        else if (cmd == "idle")
            repeat (arg) @(negedge clock);
        else if (cmd == "wait_moving")
            wait_for_motion(arg);
        else if (cmd == "wait_stopped")
            wait_for_stop(arg);
        else if (cmd == "expect_full") begin
            @(negedge clock);
            check_value("full", full, arg);
        end else begin
            $display("ERROR: unknown pattern command %0s", cmd);
            stop_run();
        end
    endtask

    task automatic run_patterns();
        int  fields;
        int  gap;
        bit  done;
        done = 1'b0;
        while (!done) begin
            fields = $fscanf(fd, "%s", cmd);
            if (fields != 1) begin
                done = 1'b1;                    // End of file
            end else if (cmd == "#") begin
                fields = $fgets(comment_text, fd);
            end else begin
                fields = $fscanf(fd, "%h", arg);
                gap = $urandom % 4;             // Idle spacing between commands
                repeat (gap) @(negedge clock);
                commands_run++;
                run_command(fields);
            end
        end
    endtask

    initial begin
        call_buttons = '0;
        emergency    = 1'b0;
        person_enter = 1'b0;
        person_exit  = 1'b0;
        reset        = 1'b1;
        commands_run = 0;
        seed         = 32'ha7a;
        void'($urandom(seed));
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        // Idle state right after reset
        check_value("stopped", stopped, 1'b1);
        check_value("moving_up", moving_up, 1'b0);
        check_value("moving_down", moving_down, 1'b0);
        check_value("floor", floor, 0);
        check_value("full", full, 1'b0);
        fd = $fopen("elevator_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open elevator_patterns.txt");
            stop_run();
        end else begin
            run_patterns();
            $fclose(fd);
            $display("Ran %0d pattern commands", commands_run);
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire
